//--- common/nn_consts.svh
`ifndef NN_CONSTS_SVH
`define NN_CONSTS_SVH

// layer sizes
`define NN_IN      2
`define NN_HID     3
`define NN_OUT     2
`define NN_NEURONS 5

// signed fixed point, Q8.24
`define NN_WIDTH   32
`define NN_FRAC    24

// weight memory address map
`define NN_ADDR_W  5
`define NN_HW_BASE 0
`define NN_HB_BASE 6
`define NN_OW_BASE 9
`define NN_OB_BASE 15
`define NN_PARAMS  17

`endif

//--- common/nn_fixed_pkg.sv
`include "nn_consts.svh"

package nn_fixed_pkg;

	typedef logic signed [`NN_WIDTH-1:0] fixed_t;

	typedef fixed_t [`NN_IN-1:0]  in_vec_t;
	typedef fixed_t [`NN_HID-1:0] hid_vec_t;
	typedef fixed_t [`NN_OUT-1:0] out_vec_t;

	localparam fixed_t FX_ONE     = fixed_t'(1) <<< `NN_FRAC;
	localparam fixed_t FX_HALF    = FX_ONE >>> 1;
	localparam fixed_t FX_QUARTER = FX_ONE >>> 2;

	// full product, then arithmetic shift back by the fraction bits
	function automatic fixed_t fx_mul(fixed_t a, fixed_t b);
		logic signed [2*`NN_WIDTH-1:0] p;
		p = a * b;
		return p[`NN_FRAC+`NN_WIDTH-1:`NN_FRAC];
	endfunction

	// hard sigmoid, clamp(x/4 + 1/2, 0, 1)
	function automatic fixed_t hard_sigmoid(fixed_t x);
		fixed_t y;
		y = (x >>> 2) + FX_HALF;
		if (y < 0)
			return '0;
		if (y > FX_ONE)
			return FX_ONE;
		return y;
	endfunction

	// derivative taken from the activation itself
	function automatic fixed_t hard_sigmoid_deriv(fixed_t a);
		return (a > 0 && a < FX_ONE) ? FX_QUARTER : '0;
	endfunction

endpackage

//--- common/nn_ctrl_pkg.sv
`include "nn_consts.svh"

package nn_ctrl_pkg;

	typedef enum logic [1:0] {
		OP_LOAD  = 2'd0,
		OP_READ  = 2'd1,
		OP_INFER = 2'd2,
		OP_TRAIN = 2'd3
	} op_e;

	typedef enum logic [2:0] {
		H_IDLE,
		H_MEM,
		H_RDATA,
		H_FF,
		H_BP
	} host_state_e;

	typedef enum logic {
		FF_IDLE,
		FF_RUN
	} ff_state_e;

	typedef enum logic [2:0] {
		BP_IDLE,
		BP_DOUT,
		BP_HDRD,
		BP_HDFIN,
		BP_URD,
		BP_UWAIT,
		BP_UWR
	} bp_state_e;

	typedef enum logic [1:0] {
		CL_HOST = 2'd0,
		CL_FF   = 2'd1,
		CL_BP   = 2'd2
	} client_e;

	// neurons 0..NN_HID-1 are hidden, the rest are outputs
	function automatic logic [1:0] fan_in(logic [2:0] neu);
		return (neu < `NN_HID) ? 2'(`NN_IN) : 2'(`NN_HID);
	endfunction

	// pos == fan_in selects the bias of the neuron
	function automatic logic [`NN_ADDR_W-1:0] param_addr(logic [2:0] neu, logic [1:0] pos);
		int n;
		int p;
		n = int'(neu);
		p = int'(pos);
		if (n < `NN_HID)
			return (p < `NN_IN) ? `NN_ADDR_W'(`NN_HW_BASE + n*`NN_IN + p)
				: `NN_ADDR_W'(`NN_HB_BASE + n);
		return (p < `NN_HID) ? `NN_ADDR_W'(`NN_OW_BASE + (n-`NN_HID)*`NN_HID + p)
			: `NN_ADDR_W'(`NN_OB_BASE + n - `NN_HID);
	endfunction

endpackage

//--- common/wmem_if.sv
`timescale 1ns/1ps
`include "nn_consts.svh"

interface wmem_if;

	logic                   req;
	logic                   we;
	logic [`NN_ADDR_W-1:0]  addr;
	nn_fixed_pkg::fixed_t   wdata;
	logic                   gnt;
	nn_fixed_pkg::fixed_t   rdata;
	// read data for this client is on rdata
	logic                   rvalid;

	modport client (
		output req, we, addr, wdata,
		input  gnt, rdata, rvalid
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output gnt, rdata, rvalid
	);

endinterface

//--- src/weight_mem.sv
`timescale 1ns/1ps
`include "nn_consts.svh"

module weight_mem (
	input  logic                  clk,
	input  logic                  i_we,
	input  logic [`NN_ADDR_W-1:0] i_addr,
	input  nn_fixed_pkg::fixed_t  i_wdata,
	output nn_fixed_pkg::fixed_t  o_rdata
);

	nn_fixed_pkg::fixed_t mem [0:(1<<`NN_ADDR_W)-1];

	// single port, registered read
	always_ff @(posedge clk)
	begin
		if (i_we)
			mem[i_addr] <= i_wdata;
		o_rdata <= mem[i_addr];
	end

endmodule

//--- src/wmem_arbiter.sv
`timescale 1ns/1ps
`include "nn_consts.svh"

module wmem_arbiter (
	input  logic                  clk,
	input  logic                  i_reset,
	wmem_if.arbiter               host,
	wmem_if.arbiter               ff,
	wmem_if.arbiter               bp,
	output logic                  o_mem_we,
	output logic [`NN_ADDR_W-1:0] o_mem_addr,
	output nn_fixed_pkg::fixed_t  o_mem_wdata,
	input  nn_fixed_pkg::fixed_t  i_mem_rdata
);

	nn_ctrl_pkg::client_e rd_client;
	logic                 rd_pend;
	logic                 any_gnt;
	nn_ctrl_pkg::client_e cur;

	// fixed priority bp > ff > host
	assign bp.gnt   = bp.req;
	assign ff.gnt   = ff.req && !bp.req;
	assign host.gnt = host.req && !ff.req && !bp.req;
	assign any_gnt  = bp.req || ff.req || host.req;

	always_comb
	begin
		cur         = nn_ctrl_pkg::CL_HOST;
		o_mem_we    = host.req && host.we;
		o_mem_addr  = host.addr;
		o_mem_wdata = host.wdata;
		if (bp.req)
		begin
			cur         = nn_ctrl_pkg::CL_BP;
			o_mem_we    = bp.we;
			o_mem_addr  = bp.addr;
			o_mem_wdata = bp.wdata;
		end
		else if (ff.req)
		begin
			cur         = nn_ctrl_pkg::CL_FF;
			o_mem_we    = ff.we;
			o_mem_addr  = ff.addr;
			o_mem_wdata = ff.wdata;
		end
	end

	// remember who issued the read in flight
	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			rd_pend   <= 1'b0;
			rd_client <= nn_ctrl_pkg::CL_HOST;
		end
		else
		begin
			rd_pend   <= any_gnt && !o_mem_we;
			rd_client <= cur;
		end
	end

	assign host.rdata  = i_mem_rdata;
	assign ff.rdata    = i_mem_rdata;
	assign bp.rdata    = i_mem_rdata;
	assign host.rvalid = rd_pend && rd_client == nn_ctrl_pkg::CL_HOST;
	assign ff.rvalid   = rd_pend && rd_client == nn_ctrl_pkg::CL_FF;
	assign bp.rvalid   = rd_pend && rd_client == nn_ctrl_pkg::CL_BP;

endmodule

//--- src/host_ctrl.sv
`timescale 1ns/1ps
`include "nn_consts.svh"

module host_ctrl (
	input  logic                  clk,
	input  logic                  i_reset,
	input  logic                  i_start,
	input  nn_ctrl_pkg::op_e      i_op,
	input  logic [`NN_ADDR_W-1:0] i_addr,
	input  nn_fixed_pkg::fixed_t  i_wdata,
	wmem_if.client                mem,
	output logic                  o_ff_start,
	input  logic                  i_ff_done,
	output logic                  o_bp_start,
	input  logic                  i_bp_done,
	output nn_fixed_pkg::fixed_t  o_rdata,
	output logic                  o_busy,
	output logic                  o_done
);

	nn_ctrl_pkg::host_state_e state;
	nn_ctrl_pkg::op_e         op_q;
	logic [`NN_ADDR_W-1:0]    addr_q;
	nn_fixed_pkg::fixed_t     wdata_q;
	logic                     is_pass;

	assign is_pass = i_op == nn_ctrl_pkg::OP_INFER || i_op == nn_ctrl_pkg::OP_TRAIN;

	// start pulses leave in the same cycle so the units see the sampled inputs
	assign o_ff_start = state == nn_ctrl_pkg::H_IDLE && i_start && is_pass;
	assign o_bp_start = state == nn_ctrl_pkg::H_FF && i_ff_done
		&& op_q == nn_ctrl_pkg::OP_TRAIN;
	assign o_busy     = state != nn_ctrl_pkg::H_IDLE;

	assign mem.req   = state == nn_ctrl_pkg::H_MEM;
	assign mem.we    = op_q == nn_ctrl_pkg::OP_LOAD;
	assign mem.addr  = addr_q;
	assign mem.wdata = wdata_q;

	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			state  <= nn_ctrl_pkg::H_IDLE;
			op_q   <= nn_ctrl_pkg::OP_LOAD;
			o_done <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			case (state)
				nn_ctrl_pkg::H_IDLE:
					if (i_start)
					begin
						op_q    <= i_op;
						addr_q  <= i_addr;
						wdata_q <= i_wdata;
						state   <= is_pass ? nn_ctrl_pkg::H_FF : nn_ctrl_pkg::H_MEM;
					end
				nn_ctrl_pkg::H_MEM:
					if (mem.gnt)
					begin
						if (op_q == nn_ctrl_pkg::OP_LOAD)
						begin
							o_done <= 1'b1;
							state  <= nn_ctrl_pkg::H_IDLE;
						end
						else
							state <= nn_ctrl_pkg::H_RDATA;
					end
				nn_ctrl_pkg::H_RDATA:
					if (mem.rvalid)
					begin
						o_rdata <= mem.rdata;
						o_done  <= 1'b1;
						state   <= nn_ctrl_pkg::H_IDLE;
					end
				nn_ctrl_pkg::H_FF:
					if (i_ff_done)
					begin
						if (op_q == nn_ctrl_pkg::OP_TRAIN)
							state <= nn_ctrl_pkg::H_BP;
						else
						begin
							o_done <= 1'b1;
							state  <= nn_ctrl_pkg::H_IDLE;
						end
					end
				nn_ctrl_pkg::H_BP:
					if (i_bp_done)
					begin
						o_done <= 1'b1;
						state  <= nn_ctrl_pkg::H_IDLE;
					end
				default:
					state <= nn_ctrl_pkg::H_IDLE;
			endcase
		end
	end

endmodule

//--- ff/ff_unit.sv
`timescale 1ns/1ps
`include "nn_consts.svh"

module ff_unit (
	input  logic                   clk,
	input  logic                   i_reset,
	input  logic                   i_start,
	input  nn_fixed_pkg::in_vec_t  i_x,
	wmem_if.client                 mem,
	output nn_fixed_pkg::hid_vec_t o_hid_a,
	output nn_fixed_pkg::out_vec_t o_out_a,
	output logic                   o_done
);

	nn_ctrl_pkg::ff_state_e state;
	nn_fixed_pkg::in_vec_t  x_q;
	nn_fixed_pkg::fixed_t   acc;
	nn_fixed_pkg::fixed_t   operand;
	nn_fixed_pkg::fixed_t   sum;

	// issue side and receive side walk the same parameter order
	logic [2:0] iss_neu;
	logic [1:0] iss_pos;
	logic       iss_end;
	logic [2:0] rcv_neu;
	logic [1:0] rcv_pos;
	logic       iss_bias;
	logic       rcv_bias;

	assign iss_bias = iss_pos == nn_ctrl_pkg::fan_in(iss_neu);
	assign rcv_bias = rcv_pos == nn_ctrl_pkg::fan_in(rcv_neu);

	assign mem.req   = state == nn_ctrl_pkg::FF_RUN && !iss_end;
	assign mem.we    = 1'b0;
	assign mem.addr  = nn_ctrl_pkg::param_addr(iss_neu, iss_pos);
	assign mem.wdata = '0;

	// input of the current product, x for hidden and hidden activation for outputs
	always_comb
	begin
		operand = '0;
		if (!rcv_bias)
		begin
			if (rcv_neu < `NN_HID)
				operand = x_q[rcv_pos[0]];
			else
				operand = o_hid_a[rcv_pos];
		end
		sum = acc + (rcv_bias ? mem.rdata : nn_fixed_pkg::fx_mul(mem.rdata, operand));
	end

	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			state   <= nn_ctrl_pkg::FF_IDLE;
			iss_end <= 1'b0;
			o_done  <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			case (state)
				nn_ctrl_pkg::FF_IDLE:
					if (i_start)
					begin
						x_q     <= i_x;
						acc     <= '0;
						iss_neu <= '0;
						iss_pos <= '0;
						rcv_neu <= '0;
						rcv_pos <= '0;
						iss_end <= 1'b0;
						state   <= nn_ctrl_pkg::FF_RUN;
					end
				nn_ctrl_pkg::FF_RUN:
				begin
					if (mem.req && mem.gnt)
					begin
						if (iss_bias)
						begin
							iss_pos <= '0;
							iss_neu <= iss_neu + 3'd1;
							if (iss_neu == `NN_NEURONS-1)
								iss_end <= 1'b1;
						end
						else
							iss_pos <= iss_pos + 2'd1;
					end
					if (mem.rvalid)
					begin
						if (rcv_bias)
						begin
							acc     <= '0;
							rcv_pos <= '0;
							rcv_neu <= rcv_neu + 3'd1;
							if (rcv_neu < `NN_HID)
								o_hid_a[rcv_neu] <= nn_fixed_pkg::hard_sigmoid(sum);
							else
								o_out_a[rcv_neu - 3'(`NN_HID)] <= nn_fixed_pkg::hard_sigmoid(sum);
							if (rcv_neu == `NN_NEURONS-1)
							begin
								o_done <= 1'b1;
								state  <= nn_ctrl_pkg::FF_IDLE;
							end
						end
						else
						begin
							acc     <= sum;
							rcv_pos <= rcv_pos + 2'd1;
						end
					end
				end
				default:
					state <= nn_ctrl_pkg::FF_IDLE;
			endcase
		end
	end

endmodule

//--- bp/bp_unit.sv
`timescale 1ns/1ps
`include "nn_consts.svh"

module bp_unit (
	input  logic                   clk,
	input  logic                   i_reset,
	input  logic                   i_start,
	input  nn_fixed_pkg::in_vec_t  i_x,
	input  nn_fixed_pkg::out_vec_t i_t,
	input  nn_fixed_pkg::fixed_t   i_lr,
	input  nn_fixed_pkg::hid_vec_t i_hid_a,
	input  nn_fixed_pkg::out_vec_t i_out_a,
	wmem_if.client                 mem,
	output nn_fixed_pkg::fixed_t   o_cost,
	output logic                   o_done
);

	nn_ctrl_pkg::bp_state_e state;
	nn_fixed_pkg::out_vec_t d_out;
	nn_fixed_pkg::hid_vec_t d_hid;
	nn_fixed_pkg::out_vec_t d_out_c;
	nn_fixed_pkg::fixed_t   cost_c;
	nn_fixed_pkg::fixed_t   err;

	// hidden delta pass over the old output weights
	logic [2:0] hd_iss;
	logic [1:0] hd_j;
	logic       hd_k;

	// update pass
	logic [2:0]           neu;
	logic [1:0]           pos;
	logic                 is_bias;
	logic                 last;
	nn_fixed_pkg::fixed_t delta;
	nn_fixed_pkg::fixed_t act;
	nn_fixed_pkg::fixed_t w_new;

	//////////////////////////////////////////////////////////
	// output deltas and cost
	//////////////////////////////////////////////////////////

	always_comb
	begin
		cost_c = '0;
		for (int k = 0; k < `NN_OUT; k++)
		begin
			err        = i_out_a[k] - i_t[k];
			d_out_c[k] = nn_fixed_pkg::fx_mul(err, nn_fixed_pkg::hard_sigmoid_deriv(i_out_a[k]));
			cost_c     = cost_c + nn_fixed_pkg::fx_mul(err, err);
		end
		cost_c = cost_c >>> 1;
	end

	//////////////////////////////////////////////////////////
	// parameter selection for the update
	//////////////////////////////////////////////////////////

	assign is_bias = pos == nn_ctrl_pkg::fan_in(neu);
	assign last    = is_bias && neu == `NN_NEURONS-1;

	// bias uses an activation of 1.0
	always_comb
	begin
		act = nn_fixed_pkg::FX_ONE;
		if (neu < `NN_HID)
		begin
			delta = d_hid[neu[1:0]];
			if (!is_bias)
				act = i_x[pos[0]];
		end
		else
		begin
			delta = d_out[neu[0] ^ 1'b1];
			if (!is_bias)
				act = i_hid_a[pos];
		end
	end

	always_comb
	begin
		mem.req   = 1'b0;
		mem.we    = 1'b0;
		mem.addr  = nn_ctrl_pkg::param_addr(neu, pos);
		mem.wdata = w_new;
		case (state)
			nn_ctrl_pkg::BP_HDRD:
			begin
				mem.req  = hd_iss < `NN_OUT*`NN_HID;
				mem.addr = `NN_ADDR_W'(`NN_OW_BASE) + `NN_ADDR_W'(hd_iss);
			end
			nn_ctrl_pkg::BP_URD:
				mem.req = 1'b1;
			nn_ctrl_pkg::BP_UWR:
			begin
				mem.req = 1'b1;
				mem.we  = 1'b1;
			end
			default:
				mem.req = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			state  <= nn_ctrl_pkg::BP_IDLE;
			o_done <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			case (state)
				nn_ctrl_pkg::BP_IDLE:
					if (i_start)
						state <= nn_ctrl_pkg::BP_DOUT;
				nn_ctrl_pkg::BP_DOUT:
				begin
					d_out  <= d_out_c;
					o_cost <= cost_c;
					d_hid  <= '0;
					hd_iss <= '0;
					hd_j   <= '0;
					hd_k   <= 1'b0;
					state  <= nn_ctrl_pkg::BP_HDRD;
				end
				nn_ctrl_pkg::BP_HDRD:
				begin
					if (mem.req && mem.gnt)
						hd_iss <= hd_iss + 3'd1;
					if (mem.rvalid)
					begin
						d_hid[hd_j] <= d_hid[hd_j] + nn_fixed_pkg::fx_mul(mem.rdata, d_out[hd_k]);
						if (hd_j == `NN_HID-1)
						begin
							hd_j <= '0;
							hd_k <= 1'b1;
							if (hd_k)
								state <= nn_ctrl_pkg::BP_HDFIN;
						end
						else
							hd_j <= hd_j + 2'd1;
					end
				end
				nn_ctrl_pkg::BP_HDFIN:
				begin
					for (int j = 0; j < `NN_HID; j++)
						d_hid[j] <= nn_fixed_pkg::fx_mul(d_hid[j],
							nn_fixed_pkg::hard_sigmoid_deriv(i_hid_a[j]));
					neu   <= '0;
					pos   <= '0;
					state <= nn_ctrl_pkg::BP_URD;
				end
				nn_ctrl_pkg::BP_URD:
					if (mem.gnt)
						state <= nn_ctrl_pkg::BP_UWAIT;
				nn_ctrl_pkg::BP_UWAIT:
					if (mem.rvalid)
					begin
						// w -= lr * (delta * act)
						w_new <= mem.rdata - nn_fixed_pkg::fx_mul(i_lr,
							nn_fixed_pkg::fx_mul(delta, act));
						state <= nn_ctrl_pkg::BP_UWR;
					end
				nn_ctrl_pkg::BP_UWR:
					if (mem.gnt)
					begin
						if (last)
						begin
							o_done <= 1'b1;
							state  <= nn_ctrl_pkg::BP_IDLE;
						end
						else
						begin
							if (is_bias)
							begin
								pos <= '0;
								neu <= neu + 3'd1;
							end
							else
								pos <= pos + 2'd1;
							state <= nn_ctrl_pkg::BP_URD;
						end
					end
				default:
					state <= nn_ctrl_pkg::BP_IDLE;
			endcase
		end
	end

endmodule

//--- src/nn_trainer_top.sv
`timescale 1ns/1ps
`include "nn_consts.svh"

module nn_trainer_top (
	input  logic                   clk,
	input  logic                   i_reset,
	input  logic                   i_start,
	input  nn_ctrl_pkg::op_e       i_op,
	input  logic [`NN_ADDR_W-1:0]  i_addr,
	input  nn_fixed_pkg::fixed_t   i_wdata,
	input  nn_fixed_pkg::in_vec_t  i_x,
	input  nn_fixed_pkg::out_vec_t i_t,
	input  nn_fixed_pkg::fixed_t   i_lr,
	output logic                   o_busy,
	output logic                   o_done,
	output nn_fixed_pkg::fixed_t   o_rdata,
	output nn_fixed_pkg::out_vec_t o_y,
	output nn_fixed_pkg::fixed_t   o_cost
);

	wmem_if host_if ();
	wmem_if ff_if ();
	wmem_if bp_if ();

	logic                   mem_we;
	logic [`NN_ADDR_W-1:0]  mem_addr;
	nn_fixed_pkg::fixed_t   mem_wdata;
	nn_fixed_pkg::fixed_t   mem_rdata;
	logic                   ff_start;
	logic                   ff_done;
	logic                   bp_start;
	logic                   bp_done;
	nn_fixed_pkg::hid_vec_t hid_a;

	weight_mem i_weight_mem (
		.clk     (clk),
		.i_we    (mem_we),
		.i_addr  (mem_addr),
		.i_wdata (mem_wdata),
		.o_rdata (mem_rdata)
	);

	wmem_arbiter i_wmem_arbiter (
		.clk         (clk),
		.i_reset     (i_reset),
		.host        (host_if.arbiter),
		.ff          (ff_if.arbiter),
		.bp          (bp_if.arbiter),
		.o_mem_we    (mem_we),
		.o_mem_addr  (mem_addr),
		.o_mem_wdata (mem_wdata),
		.i_mem_rdata (mem_rdata)
	);

	host_ctrl i_host_ctrl (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_start    (i_start),
		.i_op       (i_op),
		.i_addr     (i_addr),
		.i_wdata    (i_wdata),
		.mem        (host_if.client),
		.o_ff_start (ff_start),
		.i_ff_done  (ff_done),
		.o_bp_start (bp_start),
		.i_bp_done  (bp_done),
		.o_rdata    (o_rdata),
		.o_busy     (o_busy),
		.o_done     (o_done)
	);

	ff_unit i_ff_unit (
		.clk     (clk),
		.i_reset (i_reset),
		.i_start (ff_start),
		.i_x     (i_x),
		.mem     (ff_if.client),
		.o_hid_a (hid_a),
		.o_out_a (o_y),
		.o_done  (ff_done)
	);

	bp_unit i_bp_unit (
		.clk     (clk),
		.i_reset (i_reset),
		.i_start (bp_start),
		.i_x     (i_x),
		.i_t     (i_t),
		.i_lr    (i_lr),
		.i_hid_a (hid_a),
		.i_out_a (o_y),
		.mem     (bp_if.client),
		.o_cost  (o_cost),
		.o_done  (bp_done)
	);

endmodule

//--- tb/tb_nn_tasks.svh
`ifndef TB_NN_TASKS_SVH
`define TB_NN_TASKS_SVH

////////////////////////////////////////////////////////////
// check and drive helpers
////////////////////////////////////////////////////////////

task automatic check_value(string name, int expected, logic [31:0] actual);
	checks++;
	if (actual !== expected)
	begin
		errors++;
		$display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
	end
endtask

task automatic wait_done(output bit ok);
	int n;
	ok = 1'b0;
	for (n = 0; n < DONE_LIMIT && !ok; n++)
	begin
		@(negedge clk);
		ok = done;
	end
	if (!ok)
	begin
		errors++;
		$display("timeout at %0t ns, o_done did not arrive in %0d cycles", $time, DONE_LIMIT);
	end
endtask

task automatic run_op(nn_ctrl_pkg::op_e code, int a, int wd, output bit ok);
	@(posedge clk);
	start <= 1'b1;
	op    <= code;
	addr  <= `NN_ADDR_W'(a);
	wdata <= wd;
	@(posedge clk);
	start <= 1'b0;
	wait_done(ok);
endtask

// x, t and lr stay put for the whole operation
task automatic set_sample(int x0, int x1, int t0, int t1, int rate);
	@(posedge clk);
	x[0] <= x0;
	x[1] <= x1;
	t[0] <= t0;
	t[1] <= t1;
	lr   <= rate;
endtask

// uniform in +-0.5
task automatic randomize_words();
	int i;
	int r;
	for (i = 0; i < `NN_PARAMS; i++)
	begin
		r          = $random(seed);
		model_w[i] = r >>> 8;
	end
endtask

task automatic load_words();
	int i;
	bit ok;
	for (i = 0; i < `NN_PARAMS; i++)
		run_op(nn_ctrl_pkg::OP_LOAD, i, model_w[i], ok);
endtask

task automatic check_words();
	int i;
	bit ok;
	for (i = 0; i < `NN_PARAMS; i++)
	begin
		run_op(nn_ctrl_pkg::OP_READ, i, 0, ok);
		if (ok)
			check_value($sformatf("o_rdata @%0d", i), model_w[i], rdata);
	end
endtask

////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////

task automatic load_and_readback();
	check_value("o_busy", 0, 32'(busy));
	check_value("o_done", 0, 32'(done));
	randomize_words();
	load_words();
	check_words();
endtask

task automatic infer_vs_model();
	int n;
	int x0;
	int x1;
	bit ok;
	for (n = 0; n < 4; n++)
	begin
		x0 = $random(seed) >>> 7;
		x1 = $random(seed) >>> 7;
		set_sample(x0, x1, 0, 0, 0);
		forward_ref(x0, x1);
		run_op(nn_ctrl_pkg::OP_INFER, 0, 0, ok);
		if (ok)
		begin
			check_value("o_y[0]", m_out[0], y[0]);
			check_value("o_y[1]", m_out[1], y[1]);
		end
	end
endtask

task automatic train_vs_model();
	int x0;
	int x1;
	int t0;
	int t1;
	bit ok;
	x0 = $random(seed) >>> 7;
	x1 = $random(seed) >>> 7;
	t0 = $random(seed) & (Q_ONE - 1);
	t1 = $random(seed) & (Q_ONE - 1);
	set_sample(x0, x1, t0, t1, Q_ONE / 2);
	train_ref(x0, x1, t0, t1, Q_ONE / 2);
	run_op(nn_ctrl_pkg::OP_TRAIN, 0, 0, ok);
	if (ok)
	begin
		check_value("o_cost", m_cost, cost);
		check_value("o_y[0]", m_out[0], y[0]);
		check_value("o_y[1]", m_out[1], y[1]);
	end
	check_words();
endtask

task automatic start_while_busy();
	int x0;
	int x1;
	int n;
	int seen;
	bit ok;
	x0 = $random(seed) >>> 7;
	x1 = $random(seed) >>> 7;
	set_sample(x0, x1, 0, 0, 0);
	forward_ref(x0, x1);
	@(posedge clk);
	start <= 1'b1;
	op    <= nn_ctrl_pkg::OP_INFER;
	@(posedge clk);
	start <= 1'b0;
	@(negedge clk);
	check_value("o_busy", 1, 32'(busy));
	// a load to word 0 that has to be dropped
	@(posedge clk);
	start <= 1'b1;
	op    <= nn_ctrl_pkg::OP_LOAD;
	addr  <= '0;
	wdata <= ~model_w[0];
	@(posedge clk);
	start <= 1'b0;
	seen = 0;
	for (n = 0; n < DONE_LIMIT; n++)
	begin
		@(negedge clk);
		if (done)
		begin
			seen++;
			if (seen == 1)
			begin
				check_value("o_y[0]", m_out[0], y[0]);
				check_value("o_y[1]", m_out[1], y[1]);
			end
		end
	end
	check_value("o_done count", 1, seen);
	check_value("o_busy", 0, 32'(busy));
	run_op(nn_ctrl_pkg::OP_READ, 0, 0, ok);
	if (ok)
		check_value("o_rdata @0", model_w[0], rdata);
endtask

task automatic repeated_train();
	int x0;
	int x1;
	int t0;
	int t1;
	int step;
	int prev;
	bit ok;
	x0 = $random(seed) >>> 7;
	x1 = $random(seed) >>> 7;
	t0 = $random(seed) & (Q_ONE - 1);
	t1 = $random(seed) & (Q_ONE - 1);
	set_sample(x0, x1, t0, t1, Q_ONE / 4);
	prev = 0;
	for (step = 0; step < 3; step++)
	begin
		train_ref(x0, x1, t0, t1, Q_ONE / 4);
		run_op(nn_ctrl_pkg::OP_TRAIN, 0, 0, ok);
		if (ok)
		begin
			check_value($sformatf("o_cost step %0d", step), m_cost, cost);
			checks++;
			if (step > 0 && cost > prev)
			begin
				errors++;
				$display("cost went up from %h to %h on step %0d", prev, cost, step);
			end
			prev = cost;
		end
	end
	check_words();
endtask

// hidden units and output 0 saturate while output 1 sends a gradient back
task automatic saturated_train();
	bit ok;
	model_w[`NN_HW_BASE + 0]  = Q_ONE / 2;
	model_w[`NN_HW_BASE + 1]  = -Q_ONE / 2;
	model_w[`NN_HW_BASE + 2]  = -Q_ONE / 2;
	model_w[`NN_HW_BASE + 3]  = Q_ONE / 2;
	model_w[`NN_HW_BASE + 4]  = Q_ONE / 2;
	model_w[`NN_HW_BASE + 5]  = Q_ONE / 4;
	model_w[`NN_HB_BASE + 0]  = 0;
	model_w[`NN_HB_BASE + 1]  = 0;
	model_w[`NN_HB_BASE + 2]  = Q_ONE / 4;
	model_w[`NN_OW_BASE + 0]  = 2 * Q_ONE;
	model_w[`NN_OW_BASE + 1]  = Q_ONE / 2;
	model_w[`NN_OW_BASE + 2]  = 2 * Q_ONE;
	model_w[`NN_OW_BASE + 3]  = Q_ONE / 4;
	model_w[`NN_OW_BASE + 4]  = Q_ONE / 2;
	model_w[`NN_OW_BASE + 5]  = -Q_ONE / 2;
	model_w[`NN_OB_BASE + 0]  = Q_ONE / 4;
	model_w[`NN_OB_BASE + 1]  = 0;
	load_words();
	// hidden sums 8, -8 and 2.25, output sums 4.25 and -0.25
	set_sample(8 * Q_ONE, -8 * Q_ONE, Q_ONE / 2, Q_ONE / 2, Q_ONE / 2);
	train_ref(8 * Q_ONE, -8 * Q_ONE, Q_ONE / 2, Q_ONE / 2, Q_ONE / 2);
	run_op(nn_ctrl_pkg::OP_TRAIN, 0, 0, ok);
	if (ok)
	begin
		check_value("o_y[0]", Q_ONE, y[0]);
		check_value("o_y[1]", m_out[1], y[1]);
		check_value("o_cost", m_cost, cost);
	end
	// zero slope on every hidden unit keeps the hidden words as loaded
	check_words();
endtask

`endif

//--- tb/tb_nn_trainer.sv
`timescale 1ns/1ps
`include "nn_consts.svh"

module tb_nn_trainer;

	localparam int Q_ONE      = 1 << `NN_FRAC;
	localparam int DONE_LIMIT = 200;

	logic                   clk;
	logic                   reset;
	logic                   start;
	nn_ctrl_pkg::op_e       op;
	logic [`NN_ADDR_W-1:0]  addr;
	nn_fixed_pkg::fixed_t   wdata;
	nn_fixed_pkg::in_vec_t  x;
	nn_fixed_pkg::out_vec_t t;
	nn_fixed_pkg::fixed_t   lr;
	logic                   busy;
	logic                   done;
	nn_fixed_pkg::fixed_t   rdata;
	nn_fixed_pkg::out_vec_t y;
	nn_fixed_pkg::fixed_t   cost;

	int seed;
	int errors;
	int checks;

	// reference parameters, same layout as the weight memory
	int model_w [0:`NN_PARAMS-1];
	int m_hid [0:`NN_HID-1];
	int m_out [0:`NN_OUT-1];
	int m_cost;

	nn_trainer_top i_nn_trainer_top (
		.clk     (clk),
		.i_reset (reset),
		.i_start (start),
		.i_op    (op),
		.i_addr  (addr),
		.i_wdata (wdata),
		.i_x     (x),
		.i_t     (t),
		.i_lr    (lr),
		.o_busy  (busy),
		.o_done  (done),
		.o_rdata (rdata),
		.o_y     (y),
		.o_cost  (cost)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// Q8.24 product, arithmetic shift back
	function automatic int mul_q24(int a, int b);
		longint p;
		p = longint'(a) * longint'(b);
		return int'(p >>> `NN_FRAC);
	endfunction

	// clamp(s/4 + 1/2, 0, 1)
	function automatic int hsig_ref(int s);
		int v;
		v = (s >>> 2) + Q_ONE / 2;
		if (v < 0)
			return 0;
		if (v > Q_ONE)
			return Q_ONE;
		return v;
	endfunction

	// 1/4 only while the activation sits strictly inside (0, 1)
	function automatic int hsig_slope(int a);
		if (a > 0 && a < Q_ONE)
			return Q_ONE / 4;
		return 0;
	endfunction

	function automatic void forward_ref(int x0, int x1);
		int xin [0:`NN_IN-1];
		int acc;
		int i;
		int j;
		int k;
		xin[0] = x0;
		xin[1] = x1;
		for (j = 0; j < `NN_HID; j++)
		begin
			acc = model_w[`NN_HB_BASE + j];
			for (i = 0; i < `NN_IN; i++)
				acc += mul_q24(model_w[`NN_HW_BASE + j*`NN_IN + i], xin[i]);
			m_hid[j] = hsig_ref(acc);
		end
		for (k = 0; k < `NN_OUT; k++)
		begin
			acc = model_w[`NN_OB_BASE + k];
			for (j = 0; j < `NN_HID; j++)
				acc += mul_q24(model_w[`NN_OW_BASE + k*`NN_HID + j], m_hid[j]);
			m_out[k] = hsig_ref(acc);
		end
	endfunction

	function automatic void train_ref(int x0, int x1, int t0, int t1, int rate);
		int xin [0:`NN_IN-1];
		int tgt [0:`NN_OUT-1];
		int d_out [0:`NN_OUT-1];
		int d_hid [0:`NN_HID-1];
		int err;
		int sum;
		int i;
		int j;
		int k;
		forward_ref(x0, x1);
		xin[0] = x0;
		xin[1] = x1;
		tgt[0] = t0;
		tgt[1] = t1;
		sum = 0;
		for (k = 0; k < `NN_OUT; k++)
		begin
			err      = m_out[k] - tgt[k];
			d_out[k] = mul_q24(err, hsig_slope(m_out[k]));
			sum     += mul_q24(err, err);
		end
		m_cost = sum >>> 1;
		// hidden deltas see the output weights before the update
		for (j = 0; j < `NN_HID; j++)
		begin
			sum = 0;
			for (k = 0; k < `NN_OUT; k++)
				sum += mul_q24(model_w[`NN_OW_BASE + k*`NN_HID + j], d_out[k]);
			d_hid[j] = mul_q24(sum, hsig_slope(m_hid[j]));
		end
		for (j = 0; j < `NN_HID; j++)
		begin
			for (i = 0; i < `NN_IN; i++)
				model_w[`NN_HW_BASE + j*`NN_IN + i] -= mul_q24(rate, mul_q24(d_hid[j], xin[i]));
			model_w[`NN_HB_BASE + j] -= mul_q24(rate, d_hid[j]);
		end
		for (k = 0; k < `NN_OUT; k++)
		begin
			for (j = 0; j < `NN_HID; j++)
				model_w[`NN_OW_BASE + k*`NN_HID + j] -= mul_q24(rate, mul_q24(d_out[k], m_hid[j]));
			model_w[`NN_OB_BASE + k] -= mul_q24(rate, d_out[k]);
		end
	endfunction

	`include "tb_nn_tasks.svh"

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		seed   = 34314;
		errors = 0;
		checks = 0;
		reset  = 1'b1;
		start  = 1'b0;
		op     = nn_ctrl_pkg::OP_LOAD;
		addr   = '0;
		wdata  = '0;
		x      = '0;
		t      = '0;
		lr     = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		load_and_readback();
		infer_vs_model();
		train_vs_model();
		start_while_busy();
		repeated_train();
		saturated_train();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+common
+incdir+tb
common/nn_fixed_pkg.sv
common/nn_ctrl_pkg.sv
common/wmem_if.sv
src/weight_mem.sv
src/wmem_arbiter.sv
src/host_ctrl.sv
ff/ff_unit.sv
bp/bp_unit.sv
src/nn_trainer_top.sv
tb/tb_nn_trainer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the nn trainer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
	--top-module tb_nn_trainer \
	-f verilog.f \
	-o sim_nn_trainer

./obj_dir/sim_nn_trainer > sim.log 2>&1
cat sim.log

if grep -qx ">>> PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
